// ==== source/aes_config.svh ====
// Word, block, words-per-block and entry FIFO size macros for the AES input side

`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// Bus word width in bits
`define AES_WORD_S 32

// AES block width in bits
`define AES_BLK_S 128

// Bus words in one AES block
`define AES_NB 4

// Entry FIFO depth is 2**AES_FIFO_ADDR_WIDTH
`define AES_FIFO_ADDR_WIDTH 4

`endif

// ==== source/aes_pkg.sv ====
// Package with the shared FIFO entry union and the block byte reversal function

`default_nettype none

`include "aes_config.svh"

package aes_pkg;

	// Command view of an entry
	typedef struct packed {
		logic [`AES_BLK_S-`AES_WORD_S:0] pad;
		logic [`AES_WORD_S-1:0]          code;
	} aes_cmd_t;

	// Block view of an entry
	typedef struct packed {
		logic                  last;
		logic [`AES_BLK_S-1:0] data;
	} aes_blk_t;

	// One 129-bit FIFO entry, read as a command or as a block
	typedef union packed {
		aes_cmd_t cmd;
		aes_blk_t blk;
	} aes_entry_t;

	// Reverse the byte order of a whole block
	function automatic logic [`AES_BLK_S-1:0] blk_rev8(input logic [`AES_BLK_S-1:0] blk);
		logic [`AES_BLK_S-1:0] rev;
		rev = '0;
		for (int i = 0; i < `AES_BLK_S / 8; i++) begin
			rev[8*i +: 8] = blk[`AES_BLK_S-8-8*i +: 8];
		end
		return rev;
	endfunction

endpackage

`default_nettype wire

// ==== source/entry_fifo.sv ====
// Synchronous entry FIFO with valid/ready handshakes on the write and read sides

`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module entry_fifo #(
	parameter int ADDR_WIDTH = `AES_FIFO_ADDR_WIDTH
) (
	input  logic                bus_clk,
	input  logic                bus_reset,
	input  logic                write_valid,
	input  aes_pkg::aes_entry_t write_entry,
	output logic                write_ready,
	input  logic                read_ready,
	output logic                read_valid,
	output aes_pkg::aes_entry_t read_entry
);

	localparam int DEPTH = 1 << ADDR_WIDTH;

	aes_pkg::aes_entry_t   mem [DEPTH];
	logic [ADDR_WIDTH-1:0] wr_ptr;
	logic [ADDR_WIDTH-1:0] rd_ptr;
	logic [ADDR_WIDTH:0]   count;
	logic                  do_write;
	logic                  do_read;

	assign write_ready = (count != (ADDR_WIDTH + 1)'(DEPTH));
	assign read_valid = (count != '0);
	assign read_entry = mem[rd_ptr];

	assign do_write = write_valid && write_ready;
	assign do_read = read_valid && read_ready;

	// Storage
	always_ff @(posedge bus_clk) begin
		if (do_write) begin
			mem[wr_ptr] <= write_entry;
		end
	end

	// Pointers wrap naturally at the power-of-two depth
	always_ff @(posedge bus_clk) begin
		if (bus_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Occupancy
	always_ff @(posedge bus_clk) begin
		if (bus_reset) begin
			count <= '0;
		end else begin
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/aes_input_assembler.sv ====
// Bus word assembler that builds command and byte-reversed block entries for the FIFO

`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module aes_input_assembler (
	input  logic                   bus_clk,
	input  logic                   bus_reset,
	input  logic                   bus_data_wren,
	input  logic                   bus_tlast,
	input  logic [`AES_WORD_S-1:0] bus_data,
	input  logic                   write_ready,
	output logic                   busy,
	output logic                   write_valid,
	output aes_pkg::aes_entry_t    write_entry
);

	localparam logic ST_CMD = 1'b0;
	localparam logic ST_PAYLOAD = 1'b1;
	localparam int CNT_W = $clog2(`AES_NB);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`AES_NB - 1);

	logic                              state;
	logic [CNT_W-1:0]                  word_cnt;
	logic [`AES_BLK_S-`AES_WORD_S-1:0] blk_shift;
	logic [`AES_BLK_S-1:0]             blk_next;
	logic                              accept;
	logic                              cmd_done;
	logic                              blk_done;
	logic                              entry_taken;

	// Bus is held off until the pending entry reaches the FIFO
	assign busy = write_valid;
	assign accept = bus_data_wren && !busy;

	assign cmd_done = accept && (state == ST_CMD);
	assign blk_done = accept && (state == ST_PAYLOAD) && (word_cnt == CNT_LAST);
	assign entry_taken = write_valid && write_ready;

	// Newest word enters at the top
	assign blk_next = {bus_data, blk_shift};

	// Packet position and word count
	always_ff @(posedge bus_clk) begin
		if (bus_reset) begin
			state <= ST_CMD;
			word_cnt <= '0;
		end else if (accept) begin
			case (state)
				ST_CMD: begin
					state <= ST_PAYLOAD;
					word_cnt <= '0;
				end
				ST_PAYLOAD: begin
					if (word_cnt == CNT_LAST) begin
						word_cnt <= '0;
					end else begin
						word_cnt <= word_cnt + 1'b1;
					end
					// Packet end drops any partial block
					if (bus_tlast) begin
						state <= ST_CMD;
						word_cnt <= '0;
					end
				end
				default: begin
					state <= ST_CMD;
				end
			endcase
		end
	end

	// Block shift register keeps the three newest words
	always_ff @(posedge bus_clk) begin
		if (accept && (state == ST_PAYLOAD)) begin
			blk_shift <= blk_next[`AES_BLK_S-1:`AES_WORD_S];
		end
	end

	// Entry held stable until the FIFO takes it
	always_ff @(posedge bus_clk) begin
		if (cmd_done) begin
			write_entry.cmd.pad <= '0;
			write_entry.cmd.code <= bus_data;
		end else if (blk_done) begin
			write_entry.blk.last <= bus_tlast;
			write_entry.blk.data <= aes_pkg::blk_rev8(blk_next);
		end
	end

	always_ff @(posedge bus_clk) begin
		if (bus_reset) begin
			write_valid <= 1'b0;
		end else begin
			if (entry_taken) begin
				write_valid <= 1'b0;
			end
			if (cmd_done || blk_done) begin
				write_valid <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/aes_input_dispatcher.sv ====
// Dispatcher that pops FIFO entries and presents them as commands or blocks to the AES core

`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module aes_input_dispatcher (
	input  logic                   bus_clk,
	input  logic                   bus_reset,
	input  logic                   read_valid,
	input  aes_pkg::aes_entry_t    read_entry,
	output logic                   read_ready,
	input  logic                   out_ready,
	output logic                   out_valid,
	output logic                   out_is_cmd,
	output logic [`AES_WORD_S-1:0] out_cmd,
	output logic [`AES_BLK_S-1:0]  out_block,
	output logic                   out_block_last
);

	logic expect_cmd;
	logic pop;

	// Register free now or emptied on this edge
	assign read_ready = !out_valid || out_ready;
	assign pop = read_valid && read_ready;

	always_ff @(posedge bus_clk) begin
		if (bus_reset) begin
			expect_cmd <= 1'b1;
			out_valid <= 1'b0;
			out_is_cmd <= 1'b0;
			out_block_last <= 1'b0;
		end else if (pop) begin
			out_valid <= 1'b1;
			out_is_cmd <= expect_cmd;
			if (expect_cmd) begin
				out_block_last <= 1'b0;
				expect_cmd <= 1'b0;
			end else begin
				out_block_last <= read_entry.blk.last;
				// Last block of the packet
				expect_cmd <= read_entry.blk.last;
			end
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// Payload fields decoded by packet position
	always_ff @(posedge bus_clk) begin
		if (pop) begin
			if (expect_cmd) begin
				out_cmd <= read_entry.cmd.code;
			end else begin
				out_block <= read_entry.blk.data;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/aes_input_subsystem.sv ====
// Top level of the AES input side with the assembler, entry FIFO and dispatcher

`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module aes_input_subsystem (
	input  logic                   bus_clk,
	input  logic                   bus_reset,
	input  logic                   bus_data_wren,
	input  logic                   bus_tlast,
	input  logic [`AES_WORD_S-1:0] bus_data,
	output logic                   busy,
	input  logic                   out_ready,
	output logic                   out_valid,
	output logic                   out_is_cmd,
	output logic [`AES_WORD_S-1:0] out_cmd,
	output logic [`AES_BLK_S-1:0]  out_block,
	output logic                   out_block_last
);

	logic                write_valid;
	logic                write_ready;
	aes_pkg::aes_entry_t write_entry;
	logic                read_valid;
	logic                read_ready;
	aes_pkg::aes_entry_t read_entry;

	aes_input_assembler aes_input_assembler_inst (
		.bus_clk       (bus_clk),
		.bus_reset     (bus_reset),
		.bus_data_wren (bus_data_wren),
		.bus_tlast     (bus_tlast),
		.bus_data      (bus_data),
		.write_ready   (write_ready),
		.busy          (busy),
		.write_valid   (write_valid),
		.write_entry   (write_entry)
	);

	entry_fifo #(
		.ADDR_WIDTH (`AES_FIFO_ADDR_WIDTH)
	) entry_fifo_inst (
		.bus_clk     (bus_clk),
		.bus_reset   (bus_reset),
		.write_valid (write_valid),
		.write_entry (write_entry),
		.write_ready (write_ready),
		.read_ready  (read_ready),
		.read_valid  (read_valid),
		.read_entry  (read_entry)
	);

	aes_input_dispatcher aes_input_dispatcher_inst (
		.bus_clk        (bus_clk),
		.bus_reset      (bus_reset),
		.read_valid     (read_valid),
		.read_entry     (read_entry),
		.read_ready     (read_ready),
		.out_ready      (out_ready),
		.out_valid      (out_valid),
		.out_is_cmd     (out_is_cmd),
		.out_cmd        (out_cmd),
		.out_block      (out_block),
		.out_block_last (out_block_last)
	);

endmodule

`default_nettype wire

// ==== tests/aes_input_sva.sv ====
// Bound assertions on the AES input subsystem ports

`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module aes_input_sva (
	input logic                   bus_clk,
	input logic                   bus_reset,
	input logic                   busy,
	input logic                   out_ready,
	input logic                   out_valid,
	input logic                   out_is_cmd,
	input logic [`AES_WORD_S-1:0] out_cmd,
	input logic [`AES_BLK_S-1:0]  out_block,
	input logic                   out_block_last
);

	// Stalled output item must not change
	hold_while_stalled: assert property (@(posedge bus_clk) disable iff (bus_reset)
		out_valid && !out_ready |=> out_valid && $stable(out_is_cmd) && $stable(out_cmd)
			&& $stable(out_block) && $stable(out_block_last))
		else $error("Output item changed while stalled");

	// Bus side free right after reset
	busy_low_after_reset: assert property (@(posedge bus_clk)
		bus_reset |=> !busy)
		else $error("busy high in the cycle after reset");

	// A command never carries a block last flag
	cmd_without_last: assert property (@(posedge bus_clk) disable iff (bus_reset)
		out_is_cmd |-> !out_block_last)
		else $error("out_block_last set on a command item");

endmodule

bind aes_input_subsystem aes_input_sva aes_input_sva_inst (
	.bus_clk        (bus_clk),
	.bus_reset      (bus_reset),
	.busy           (busy),
	.out_ready      (out_ready),
	.out_valid      (out_valid),
	.out_is_cmd     (out_is_cmd),
	.out_cmd        (out_cmd),
	.out_block      (out_block),
	.out_block_last (out_block_last)
);

`default_nettype wire

// ==== tests/aes_input_tb.sv ====
// Directed testbench for the AES input subsystem with scoreboard, compare tasks and timeout

`timescale 1ns/1ps
`default_nettype none

`include "aes_config.svh"

module aes_input_tb;

	localparam int TIMEOUT_CYCLES = 4000;
	localparam int DRAIN_LIMIT = 200;

	logic                   bus_clk;
	logic                   bus_reset;
	logic                   bus_data_wren;
	logic                   bus_tlast;
	logic [`AES_WORD_S-1:0] bus_data;
	logic                   busy;
	logic                   out_ready;
	logic                   out_valid;
	logic                   out_is_cmd;
	logic [`AES_WORD_S-1:0] out_cmd;
	logic [`AES_BLK_S-1:0]  out_block;
	logic                   out_block_last;

	// Expected items in output order
	aes_pkg::aes_entry_t exp_entry[$];
	logic                exp_is_cmd[$];
	int                  cycle_count;

	aes_input_subsystem aes_input_subsystem_inst (
		.bus_clk        (bus_clk),
		.bus_reset      (bus_reset),
		.bus_data_wren  (bus_data_wren),
		.bus_tlast      (bus_tlast),
		.bus_data       (bus_data),
		.busy           (busy),
		.out_ready      (out_ready),
		.out_valid      (out_valid),
		.out_is_cmd     (out_is_cmd),
		.out_cmd        (out_cmd),
		.out_block      (out_block),
		.out_block_last (out_block_last)
	);

	always #20 bus_clk = ~bus_clk;

	task automatic report_error(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1);
	endtask

	always @(posedge bus_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			report_error($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
		end
	end

	function automatic logic [`AES_WORD_S-1:0] byte_swap(input logic [`AES_WORD_S-1:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Byte reversal of {w3, w2, w1, w0} puts the swapped w0 on top
	function automatic aes_pkg::aes_entry_t block_entry(input logic [`AES_WORD_S-1:0] w0,
		input logic [`AES_WORD_S-1:0] w1, input logic [`AES_WORD_S-1:0] w2,
		input logic [`AES_WORD_S-1:0] w3, input logic last);
		aes_pkg::aes_entry_t e;
		e.blk.last = last;
		e.blk.data = {byte_swap(w0), byte_swap(w1), byte_swap(w2), byte_swap(w3)};
		return e;
	endfunction

	task automatic compare_cmd(input logic [`AES_WORD_S-1:0] code);
		if (out_is_cmd !== 1'b1) begin
			report_error($sformatf("Mismatch out_is_cmd expected %h actual %h", 1'b1, out_is_cmd));
		end
		if (out_cmd !== code) begin
			report_error($sformatf("Mismatch out_cmd expected %h actual %h", code, out_cmd));
		end
	endtask

	task automatic compare_block(input aes_pkg::aes_entry_t exp);
		if (out_is_cmd !== 1'b0) begin
			report_error($sformatf("Mismatch out_is_cmd expected %h actual %h", 1'b0, out_is_cmd));
		end
		if (out_block !== exp.blk.data) begin
			report_error($sformatf("Mismatch out_block expected %h actual %h",
				exp.blk.data, out_block));
		end
		if (out_block_last !== exp.blk.last) begin
			report_error($sformatf("Mismatch out_block_last expected %h actual %h",
				exp.blk.last, out_block_last));
		end
	endtask

	// Output monitor with one item per handshake
	always @(posedge bus_clk) begin : monitor
		aes_pkg::aes_entry_t exp;
		logic                exp_cmd;
		if (!bus_reset && out_valid && out_ready) begin
			if (exp_entry.size() == 0) begin
				report_error("An output item arrived when none was expected");
			end else begin
				exp = exp_entry.pop_front();
				exp_cmd = exp_is_cmd.pop_front();
				if (exp_cmd) begin
					compare_cmd(exp.cmd.code);
				end else begin
					compare_block(exp);
				end
			end
		end
	end

	// One bus word held back while busy
	task automatic write_word(input logic [`AES_WORD_S-1:0] data, input logic last);
		@(posedge bus_clk);
		while (busy) begin
			@(posedge bus_clk);
		end
		bus_data_wren <= 1'b1;
		bus_data <= data;
		bus_tlast <= last;
		@(posedge bus_clk);
		bus_data_wren <= 1'b0;
		bus_tlast <= 1'b0;
	endtask

	task automatic send_command(input logic [`AES_WORD_S-1:0] code);
		aes_pkg::aes_entry_t e;
		e.cmd.pad = '0;
		e.cmd.code = code;
		exp_entry.push_back(e);
		exp_is_cmd.push_back(1'b1);
		write_word(code, 1'b0);
	endtask

	task automatic send_block(input logic [`AES_WORD_S-1:0] w0, input logic [`AES_WORD_S-1:0] w1,
		input logic [`AES_WORD_S-1:0] w2, input logic [`AES_WORD_S-1:0] w3, input logic last);
		exp_entry.push_back(block_entry(w0, w1, w2, w3, last));
		exp_is_cmd.push_back(1'b0);
		write_word(w0, 1'b0);
		write_word(w1, 1'b0);
		write_word(w2, 1'b0);
		write_word(w3, last);
	endtask

	task automatic send_random_block(input logic last);
		logic [`AES_WORD_S-1:0] w0;
		logic [`AES_WORD_S-1:0] w1;
		logic [`AES_WORD_S-1:0] w2;
		logic [`AES_WORD_S-1:0] w3;
		w0 = $urandom;
		w1 = $urandom;
		w2 = $urandom;
		w3 = $urandom;
		send_block(w0, w1, w2, w3, last);
	endtask

	task automatic drain_outputs();
		int waited;
		waited = 0;
		while (exp_entry.size() != 0) begin
			if (waited == DRAIN_LIMIT) begin
				report_error($sformatf("%0d expected output items never arrived",
					exp_entry.size()));
			end
			@(posedge bus_clk);
			waited++;
		end
	endtask

	task automatic apply_reset();
		@(posedge bus_clk);
		bus_reset <= 1'b1;
		bus_data_wren <= 1'b0;
		repeat (3) @(posedge bus_clk);
		bus_reset <= 1'b0;
	endtask

	task automatic passthrough_test();
		@(posedge bus_clk);
		out_ready <= 1'b1;
		send_command(32'hc0de0001);
		send_random_block(1'b1);
		drain_outputs();
	endtask

	task automatic assembly_test();
		send_command(32'hc0de0002);
		send_block(32'h03020100, 32'h07060504, 32'h0b0a0908, 32'h0f0e0d0c, 1'b1);
		drain_outputs();
	endtask

	task automatic multi_block_test();
		send_command($urandom);
		send_random_block(1'b0);
		send_random_block(1'b0);
		send_random_block(1'b1);
		// Next packet must start with a command again
		send_command($urandom);
		send_random_block(1'b1);
		drain_outputs();
	endtask

	task automatic backpressure_test();
		@(posedge bus_clk);
		out_ready <= 1'b0;
		send_command(32'hc0de0004);
		// Sixteen blocks fill the FIFO and the seventeenth waits in the assembler
		repeat (17) send_random_block(1'b0);
		repeat (8) begin
			@(posedge bus_clk);
			if (busy !== 1'b1) begin
				report_error($sformatf("Mismatch busy expected %h actual %h", 1'b1, busy));
			end
		end
		@(posedge bus_clk);
		out_ready <= 1'b1;
		send_random_block(1'b0);
		send_random_block(1'b1);
		drain_outputs();
	endtask

	task automatic reset_mid_block_test();
		send_command(32'hc0de0005);
		drain_outputs();
		// Partial block lost at reset
		write_word($urandom, 1'b0);
		write_word($urandom, 1'b0);
		apply_reset();
		send_command(32'hc0de0006);
		send_random_block(1'b1);
		drain_outputs();
	endtask

	task automatic streaming_test();
		@(posedge bus_clk);
		out_ready <= 1'b1;
		send_command($urandom);
		send_random_block(1'b0);
		send_random_block(1'b1);
		send_command($urandom);
		send_random_block(1'b1);
		drain_outputs();
	endtask

	initial begin
		bus_clk = 1'b0;
		bus_reset = 1'b1;
		bus_data_wren = 1'b0;
		bus_tlast = 1'b0;
		bus_data = '0;
		out_ready = 1'b0;
		cycle_count = 0;
		void'($urandom(32'hfedb0e49));
		repeat (3) @(posedge bus_clk);
		bus_reset <= 1'b0;
		passthrough_test();
		assembly_test();
		multi_block_test();
		backpressure_test();
		reset_mid_block_test();
		streaming_test();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+source
source/aes_pkg.sv
source/entry_fifo.sv
source/aes_input_assembler.sv
source/aes_input_dispatcher.sv
source/aes_input_subsystem.sv
tests/aes_input_sva.sv
tests/aes_input_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module aes_input_tb -f project.f \
	-o aes_input_sim > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }
./obj_dir/aes_input_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; } || true
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
